// ==== include/afu_cfg.svh ====
// Build-time constants of the copy AFU, included by the packages and modules that size on them.
`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

// Identifier returned by an MMIO read of CSR offset zero.
`define AFU_ID 64'h5A1C_0C0B_7E11_D0F1

// Response buffer depth in cache lines.
// The read engine uses the same number as its credit limit.
`define AFU_BUF_DEPTH 16

// Largest line count the host may program, which sets the 16-bit count width.
`define AFU_MAX_LINES 65535

`endif

// ==== src/ccipPkg.sv ====
// Field types of the CCI-P style host port, imported by every block that touches host traffic.
package ccipPkg;

   // Host memory is addressed in 64-byte cache lines.
   typedef logic [41:0]  clAddr_t;   // Cache-line address.
   typedef logic [511:0] clData_t;   // One full line of data.

   // Request tag echoed back by the host on responses and completions.
   typedef logic [15:0]  mdata_t;

   // MMIO fields on channel 0 requests and channel 2 responses.
   typedef logic [15:0]  mmioAddr_t;   // Address in 4-byte units.
   typedef logic [8:0]   mmioTid_t;    // Transaction id, returned unchanged.
   typedef logic [63:0]  mmioData_t;   // One CSR word.

   // Number of 64-bit words in a cache line.
   localparam int clWords = $bits(clData_t) / $bits(mmioData_t);

endpackage

// ==== src/afuPkg.sv ====
// Types that belong to the copy AFU itself, imported by the control module and the datapath.
`include "afu_cfg.svh"

package afuPkg;

   // CSR map in 4-byte MMIO units. Each register is 64 bits wide, so offsets step by two.
   typedef enum logic [15:0] {
      AFU_ID = 16'h0000,   // Read-only identifier.
      SRC    = 16'h0020,   // Source line address.
      DST    = 16'h0022,   // Destination line address.
      NUM    = 16'h0024,   // Number of lines to copy.
      CTL    = 16'h0026,   // Bit 0 starts a copy.
      STATUS = 16'h0028,   // Bit 0 busy, bit 1 done.
      CPL    = 16'h002A,   // Write completions seen so far.
      CHKSUM = 16'h002C    // XOR of every 64-bit word copied.
   } csrOffset_e;

   // Copy engine states.
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RUN  = 2'd1,
      DONE = 2'd2
   } copyState_e;

   // Line counts and line indices.
   typedef logic [$clog2(`AFU_MAX_LINES + 1) - 1:0] lineCnt_t;

endpackage

// ==== src/afuCtrl.sv ====
// CSR block and copy sequencer of the AFU, serving host MMIO and launching the read and write engines.
`timescale 1ns/100ps
`include "afu_cfg.svh"

module afuCtrl (
   input  logic               pClk,
   input  logic               rst,
   input  logic               c0RxMmioWrValid,
   input  logic               c0RxMmioRdValid,
   input  ccipPkg::mmioAddr_t c0RxMmioAddr,
   input  ccipPkg::mmioTid_t  c0RxMmioTid,
   input  ccipPkg::mmioData_t c0RxMmioData,
   input  logic               c1RxWrValid,
   input  logic               lineValid,
   input  ccipPkg::mmioData_t chkWord,
   output logic               c2TxMmioRdValid,
   output ccipPkg::mmioTid_t  c2TxTid,
   output ccipPkg::mmioData_t c2TxData,
   output logic               startPulse,
   output ccipPkg::clAddr_t   srcAddr,
   output ccipPkg::clAddr_t   dstAddr,
   output afuPkg::lineCnt_t   numLines
);
   import ccipPkg::*;
   import afuPkg::*;

   copyState_e state;
   lineCnt_t   cplCnt;     // Completions returned by the host.
   mmioData_t  chkSum;     // Running XOR of copied words.
   mmioData_t  rdMux;      // CSR value selected by the read address.
   logic       busy;
   logic       startReq;   // Accepted start that becomes startPulse at the edge.
   logic       cplLast;    // This completion is the final one.

   assign busy     = (state == RUN);
   assign startReq = c0RxMmioWrValid && (c0RxMmioAddr == CTL) && c0RxMmioData[0] && !busy;
   assign cplLast  = c1RxWrValid && (lineCnt_t'(cplCnt + 1'b1) == numLines);

   //////////////////////////////////////////////////////////////////////
   // Register writes and the copy sequencer.
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge pClk) begin
      if (rst) begin
         state      <= IDLE;
         startPulse <= 1'b0;
         cplCnt     <= '0;
         chkSum     <= '0;
         srcAddr    <= '0;
         dstAddr    <= '0;
         numLines   <= '0;
      end else begin
         startPulse <= startReq;   // One cycle wide, since the state leaves IDLE or DONE at once.
         if (startReq) begin
            cplCnt <= '0;
            chkSum <= '0;
            // An empty copy has nothing to wait for.
            state  <= (numLines == '0) ? DONE : RUN;
         end else begin
            if (c1RxWrValid) cplCnt <= cplCnt + 1'b1;
            if (lineValid) chkSum <= chkSum ^ chkWord;   // Fold each line as it is written.
            if (busy && cplLast) state <= DONE;
         end
         // Copy parameters are frozen while the engines are using them.
         if (c0RxMmioWrValid && !busy) begin
            case (c0RxMmioAddr)
               SRC:     srcAddr  <= clAddr_t'(c0RxMmioData);
               DST:     dstAddr  <= clAddr_t'(c0RxMmioData);
               NUM:     numLines <= lineCnt_t'(c0RxMmioData);
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // MMIO read responses come one cycle after the request.
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (c0RxMmioAddr)
         AFU_ID:  rdMux = `AFU_ID;
         SRC:     rdMux = mmioData_t'(srcAddr);
         DST:     rdMux = mmioData_t'(dstAddr);
         NUM:     rdMux = mmioData_t'(numLines);
         STATUS:  rdMux = {62'd0, state == DONE, busy};
         CPL:     rdMux = mmioData_t'(cplCnt);
         CHKSUM:  rdMux = chkSum;
         default: rdMux = '0;   // Unmapped offsets and CTL read as zero.
      endcase
   end

   always_ff @(posedge pClk) begin
      if (rst) c2TxMmioRdValid <= 1'b0;
      else     c2TxMmioRdValid <= c0RxMmioRdValid;
   end

   // Tid and data only matter while the valid is high.
   always_ff @(posedge pClk) begin
      c2TxTid  <= c0RxMmioTid;
      c2TxData <= rdMux;
   end

   // The host only completes writes that this AFU issued during a copy.
   cplNotIdle: assert property (@(posedge pClk) disable iff (rst)
      c1RxWrValid |-> state != IDLE);

   // Every completion answers a line that is still missing, so the count never passes numLines.
   cplBounded: assert property (@(posedge pClk) disable iff (rst)
      c1RxWrValid |-> cplCnt < numLines);

endmodule

// ==== src/rdReqGen.sv ====
// Channel 0 read engine that walks the source block one line per cycle within the buffer credits.
`timescale 1ns/100ps
`include "afu_cfg.svh"

module rdReqGen (
   input  logic             pClk,
   input  logic             rst,
   input  logic             startPulse,
   input  ccipPkg::clAddr_t srcAddr,
   input  afuPkg::lineCnt_t numLines,
   input  logic             c0TxAlmFull,
   input  logic             pop,
   output logic             c0TxValid,
   output ccipPkg::clAddr_t c0TxAddr,
   output ccipPkg::mdata_t  c0TxMdata
);
   import afuPkg::*;

   localparam int credits  = `AFU_BUF_DEPTH;
   localparam int cntWidth = $clog2(credits + 1);

   lineCnt_t            nextIdx;       // Next line to request.
   lineCnt_t            baseIdx;       // Index used this cycle.
   logic                active;        // Lines remain to be requested.
   logic                running;
   logic                canIssue;
   logic [cntWidth-1:0] outstanding;   // Issued lines not yet popped from rspBuf.

   // A start restarts the walk at line zero in the same cycle.
   assign baseIdx  = startPulse ? '0 : nextIdx;
   assign running  = startPulse || active;
   assign canIssue = running && (baseIdx < numLines) && !c0TxAlmFull
                     && (outstanding < credits);

   always_ff @(posedge pClk) begin
      if (rst) begin
         c0TxValid   <= 1'b0;
         active      <= 1'b0;
         nextIdx     <= '0;
         outstanding <= '0;
      end else begin
         c0TxValid <= canIssue;   // Registered so almost-full acts on the following edge.
         if (canIssue) nextIdx <= lineCnt_t'(baseIdx + 1'b1);
         else if (startPulse) nextIdx <= '0;
         // Stop once the last line has gone out.
         active <= running && (baseIdx < numLines)
                   && !(canIssue && (lineCnt_t'(baseIdx + 1'b1) == numLines));
         case ({canIssue, pop})
            2'b10:   outstanding <= outstanding + 1'b1;
            2'b01:   outstanding <= outstanding - 1'b1;
            default: ;
         endcase
      end
   end

   // The tag carries the line index so the write side can place the line.
   always_ff @(posedge pClk) begin
      if (canIssue) begin
         c0TxAddr  <= srcAddr + baseIdx;
         c0TxMdata <= baseIdx;
      end
   end

   // The host must see no new read after a cycle in which it signalled almost-full.
   noIssueOnAlmFull: assert property (@(posedge pClk) disable iff (rst)
      c0TxAlmFull |=> !c0TxValid);

endmodule

// ==== src/rspBuf.sv ====
// Circular buffer that holds read responses until channel 1 can take them as writes.
`timescale 1ns/100ps
`include "afu_cfg.svh"

module rspBuf #(
   parameter int DEPTH = `AFU_BUF_DEPTH
) (
   input  logic             pClk,
   input  logic             rst,
   input  logic             c0RxRdValid,
   input  ccipPkg::mdata_t  c0RxMdata,
   input  ccipPkg::clData_t c0RxData,
   input  logic             c1TxAlmFull,
   output logic             pop,
   output ccipPkg::mdata_t  lineIdx,
   output ccipPkg::clData_t lineData
);
   import ccipPkg::*;

   localparam int ptrWidth = $clog2(DEPTH);
   localparam int cntWidth = $clog2(DEPTH + 1);

   mdata_t              tagMem  [DEPTH];   // Line index of each entry.
   clData_t             dataMem [DEPTH];
   logic [ptrWidth-1:0] wrPtr;
   logic [ptrWidth-1:0] rdPtr;
   logic [cntWidth-1:0] count;

   // Drain one line per cycle whenever channel 1 has room.
   assign pop      = (count != '0) && !c1TxAlmFull;
   assign lineIdx  = tagMem[rdPtr];
   assign lineData = dataMem[rdPtr];

   always_ff @(posedge pClk) begin
      if (c0RxRdValid) begin
         tagMem[wrPtr]  <= c0RxMdata;
         dataMem[wrPtr] <= c0RxData;
      end
   end

   always_ff @(posedge pClk) begin
      if (rst) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (c0RxRdValid) wrPtr <= (wrPtr == ptrWidth'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (pop) rdPtr <= (rdPtr == ptrWidth'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         case ({c0RxRdValid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;   // Push and pop together leave the fill level alone.
         endcase
      end
   end

   // Read credits in rdReqGen keep a slot free for every response still in flight.
   noPushWhenFull: assert property (@(posedge pClk) disable iff (rst)
      c0RxRdValid |-> count < DEPTH);

endmodule

// ==== src/wrReqGen.sv ====
// Channel 1 write engine that turns popped lines into writes and hands their checksum to the CSRs.
`timescale 1ns/100ps

module wrReqGen (
   input  logic                pClk,
   input  logic                rst,
   input  ccipPkg::clAddr_t    dstAddr,
   input  logic                pop,
   input  ccipPkg::mdata_t     lineIdx,
   input  ccipPkg::clData_t    lineData,
   output logic                c1TxValid,
   output ccipPkg::clAddr_t    c1TxAddr,
   output ccipPkg::mdata_t     c1TxMdata,
   output ccipPkg::clData_t    c1TxData,
   output logic                lineValid,
   output ccipPkg::mmioData_t  chkWord
);
   import ccipPkg::*;

   // XOR of all 64-bit words in a line.
   function automatic mmioData_t foldLine(input clData_t line);
      mmioData_t acc;
      acc = '0;
      for (int w = 0; w < clWords; w++) begin
         acc ^= line[w * $bits(mmioData_t) +: $bits(mmioData_t)];
      end
      return acc;
   endfunction

   always_ff @(posedge pClk) begin
      if (rst) c1TxValid <= 1'b0;
      else     c1TxValid <= pop;   // Exactly one cycle behind the pop.
   end

   // Each line returns to its own slot in the destination block.
   always_ff @(posedge pClk) begin
      if (pop) begin
         c1TxAddr  <= dstAddr + lineIdx;
         c1TxMdata <= lineIdx;
         c1TxData  <= lineData;
      end
   end

   // The checksum is taken from the line being written.
   assign lineValid = c1TxValid;
   assign chkWord   = foldLine(c1TxData);

endmodule

// ==== src/ccipStdAfu.sv ====
// Top level of the copy AFU, instantiated by the testbench or platform behind the host port.
`timescale 1ns/100ps

module ccipStdAfu (
   input  logic               pClk,
   input  logic               rst,
   // Back-pressure from the host.
   input  logic               c0TxAlmFull,
   input  logic               c1TxAlmFull,
   // Channel 0 receive, read responses and MMIO requests.
   input  logic               c0RxRdValid,
   input  ccipPkg::mdata_t    c0RxMdata,
   input  ccipPkg::clData_t   c0RxData,
   input  logic               c0RxMmioWrValid,
   input  logic               c0RxMmioRdValid,
   input  ccipPkg::mmioAddr_t c0RxMmioAddr,
   input  ccipPkg::mmioTid_t  c0RxMmioTid,
   input  ccipPkg::mmioData_t c0RxMmioData,
   // Channel 1 receive. Completions are only counted, so their tag is not decoded.
   input  logic               c1RxWrValid,
   input  ccipPkg::mdata_t    c1RxMdata,
   // Channel 0 transmit, line reads.
   output logic               c0TxValid,
   output ccipPkg::clAddr_t   c0TxAddr,
   output ccipPkg::mdata_t    c0TxMdata,
   // Channel 1 transmit, line writes.
   output logic               c1TxValid,
   output ccipPkg::clAddr_t   c1TxAddr,
   output ccipPkg::mdata_t    c1TxMdata,
   output ccipPkg::clData_t   c1TxData,
   // Channel 2 transmit, MMIO read responses.
   output logic               c2TxMmioRdValid,
   output ccipPkg::mmioTid_t  c2TxTid,
   output ccipPkg::mmioData_t c2TxData
);
   import ccipPkg::*;
   import afuPkg::*;

   logic      startPulse;
   clAddr_t   srcAddr;
   clAddr_t   dstAddr;
   lineCnt_t  numLines;
   logic      pop;         // Line leaving rspBuf this cycle.
   mdata_t    lineIdx;
   clData_t   lineData;
   logic      lineValid;   // Line written this cycle, for the checksum.
   mmioData_t chkWord;

   afuCtrl afuCtrl_i (
      .pClk            (pClk           ),
      .rst             (rst            ),
      .c0RxMmioWrValid (c0RxMmioWrValid),
      .c0RxMmioRdValid (c0RxMmioRdValid),
      .c0RxMmioAddr    (c0RxMmioAddr   ),
      .c0RxMmioTid     (c0RxMmioTid    ),
      .c0RxMmioData    (c0RxMmioData   ),
      .c1RxWrValid     (c1RxWrValid    ),
      .lineValid       (lineValid      ),
      .chkWord         (chkWord        ),
      .c2TxMmioRdValid (c2TxMmioRdValid),
      .c2TxTid         (c2TxTid        ),
      .c2TxData        (c2TxData       ),
      .startPulse      (startPulse     ),
      .srcAddr         (srcAddr        ),
      .dstAddr         (dstAddr        ),
      .numLines        (numLines       )
   );

   rdReqGen rdReqGen_i (
      .pClk        (pClk       ),
      .rst         (rst        ),
      .startPulse  (startPulse ),
      .srcAddr     (srcAddr    ),
      .numLines    (numLines   ),
      .c0TxAlmFull (c0TxAlmFull),
      .pop         (pop        ),
      .c0TxValid   (c0TxValid  ),
      .c0TxAddr    (c0TxAddr   ),
      .c0TxMdata   (c0TxMdata  )
   );

   rspBuf rspBuf_i (
      .pClk        (pClk       ),
      .rst         (rst        ),
      .c0RxRdValid (c0RxRdValid),
      .c0RxMdata   (c0RxMdata  ),
      .c0RxData    (c0RxData   ),
      .c1TxAlmFull (c1TxAlmFull),
      .pop         (pop        ),
      .lineIdx     (lineIdx    ),
      .lineData    (lineData   )
   );

   wrReqGen wrReqGen_i (
      .pClk      (pClk     ),
      .rst       (rst      ),
      .dstAddr   (dstAddr  ),
      .pop       (pop      ),
      .lineIdx   (lineIdx  ),
      .lineData  (lineData ),
      .c1TxValid (c1TxValid),
      .c1TxAddr  (c1TxAddr ),
      .c1TxMdata (c1TxMdata),
      .c1TxData  (c1TxData ),
      .lineValid (lineValid),
      .chkWord   (chkWord  )
   );

endmodule

// ==== verif/tbClkGen.sv ====
// Testbench clock and reset source, instantiated once by tbTop to drive the AFU's pClk and rst.
`timescale 1ns/100ps

module tbClkGen (
   output logic clk,
   output logic rst
);

   // 10 ns period, starting low.
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset is high for two rising edges and drops just after the second one.
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// ==== verif/tbTop.sv ====
// Testbench top level with the host memory model, MMIO tasks and directed copy tests of the AFU.
`timescale 1ns/100ps
`include "afu_cfg.svh"

module tbTop;
   import ccipPkg::*;
   import afuPkg::*;

   logic      pClk;
   logic      rst;
   logic      c0TxAlmFull;
   logic      c1TxAlmFull;
   logic      c0RxRdValid;
   mdata_t    c0RxMdata;
   clData_t   c0RxData;
   logic      c0RxMmioWrValid;
   logic      c0RxMmioRdValid;
   mmioAddr_t c0RxMmioAddr;
   mmioTid_t  c0RxMmioTid;
   mmioData_t c0RxMmioData;
   logic      c1RxWrValid;
   mdata_t    c1RxMdata;
   logic      c0TxValid;
   clAddr_t   c0TxAddr;
   mdata_t    c0TxMdata;
   logic      c1TxValid;
   clAddr_t   c1TxAddr;
   mdata_t    c1TxMdata;
   clData_t   c1TxData;
   logic      c2TxMmioRdValid;
   mmioTid_t  c2TxTid;
   mmioData_t c2TxData;

   clData_t   hostMem [clAddr_t];   // Host memory with one entry per cache line.
   clAddr_t   rdAddrQ [$];          // Reads waiting for their response.
   mdata_t    rdTagQ  [$];
   int        rdDueQ  [$];          // Cycle from which each read may be answered.
   mdata_t    cplTagQ [$];          // Writes waiting for their completion.

   int        issued;               // Read requests seen since time zero.
   int        written;              // Write requests seen since time zero.
   int        expRdIdx;             // Line index the next read request must carry.
   clAddr_t   curSrc;               // Block of the copy in progress.
   clAddr_t   curDst;
   lineCnt_t  curNum;
   bit        randomRsp;            // Answer reads out of order after random delays.
   bit        almMode;              // Wiggle both almost-full levels.
   mmioTid_t  nextTid;
   int        checkCount;
   int        mismatchCount;
   int        failCount;

   tbClkGen tbClkGen_i (.clk(pClk), .rst(rst));

   ccipStdAfu ccipStdAfu_i (.*);

   //////////////////////////////////////////////////////////////////////
   // Checks and stimulus helpers.
   //////////////////////////////////////////////////////////////////////

   task automatic compareValue(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
      checkCount++;
      assert (got === exp) else begin
         mismatchCount++;
         $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic expectTrue(input bit cond, input string what);
      checkCount++;
      assert (cond) else begin
         failCount++;
         $display("ERROR at %0t: %s", $time, what);
      end
   endtask

   // Every word mixes the full line address, so no two lines look alike.
   function automatic clData_t linePattern(input clAddr_t addr);
      clData_t line;
      for (int w = 0; w < 8; w++) begin
         line[64*w +: 64] = {22'd0, addr} * 64'h9E37_79B9_7F4A_7C15 + 64'(w) * 64'h0101_0101;
      end
      return line;
   endfunction

   task automatic mmioWrite(input mmioAddr_t addr, input mmioData_t data);
      @(posedge pClk);
      #1;
      c0RxMmioWrValid = 1'b1;
      c0RxMmioAddr    = addr;
      c0RxMmioData    = data;
      @(posedge pClk);   // The register takes the value here.
      #1;
      c0RxMmioWrValid = 1'b0;
   endtask

   // The response must appear exactly one cycle after the request is taken.
   task automatic mmioRead(input mmioAddr_t addr, output mmioData_t data);
      mmioTid_t tid;
      tid = nextTid;
      nextTid++;
      @(posedge pClk);
      #1;
      c0RxMmioRdValid = 1'b1;
      c0RxMmioAddr    = addr;
      c0RxMmioTid     = tid;
      @(posedge pClk);
      expectTrue(!c2TxMmioRdValid, "MMIO read response came before the request was taken");
      #1;
      c0RxMmioRdValid = 1'b0;
      @(posedge pClk);
      expectTrue(c2TxMmioRdValid, "no MMIO read response one cycle after the request");
      compareValue("c2TxTid", c2TxTid, tid);
      data = c2TxData;
   endtask

   task automatic waitCopyDone(output bit ok);
      mmioData_t status;
      int        polls;
      ok    = 1'b0;
      polls = 0;
      while (!ok && polls < 400) begin
         mmioRead(STATUS, status);
         ok = status[1];   // Done bit.
         polls++;
      end
      if (!ok) begin
         failCount++;
         $display("ERROR at %0t: copy still not done after %0d status polls", $time, polls);
      end
   endtask

   // Loads the source block, runs one copy and checks every result the host can see.
   task automatic runCopy(input clAddr_t src, input clAddr_t dst, input lineCnt_t n,
                          input bit startWhileBusy);
      mmioData_t expSum;
      mmioData_t rd;
      clData_t   line;
      int        issuedAtStart;
      bit        ok;
      expSum = '0;
      for (int i = 0; i < n; i++) begin
         line             = linePattern(src + i);
         hostMem[src + i] = line;
         for (int w = 0; w < 8; w++) begin
            expSum ^= line[64*w +: 64];   // Checksum covers every word copied.
         end
         hostMem.delete(dst + i);         // Stale data must not pass as a copied line.
      end
      curSrc        = src;
      curDst        = dst;
      curNum        = n;
      expRdIdx      = 0;
      issuedAtStart = issued;
      mmioWrite(SRC, mmioData_t'(src));
      mmioWrite(DST, mmioData_t'(dst));
      mmioWrite(NUM, mmioData_t'(n));
      mmioWrite(CTL, 64'd1);
      if (startWhileBusy) begin
         mmioRead(STATUS, rd);
         expectTrue(rd[0], "copy was not busy when the second start was written");
         mmioWrite(NUM, 64'd1);   // Frozen while busy.
         mmioWrite(CTL, 64'd1);
      end
      waitCopyDone(ok);
      if (ok) begin
         mmioRead(STATUS, rd);
         compareValue("STATUS", rd, 64'd2);
         mmioRead(CPL, rd);
         compareValue("CPL", rd, n);
         mmioRead(CHKSUM, rd);
         compareValue("CHKSUM", rd, expSum);
         compareValue("read request count", issued - issuedAtStart, n);
         for (int i = 0; i < n; i++) begin
            compareValue($sformatf("host line %0h", dst + i),
                         hostMem.exists(dst + i) ? hostMem[dst + i] : 'x,
                         hostMem[src + i]);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Host model. Samples requests at the edge and drives answers 1 ns later.
   //////////////////////////////////////////////////////////////////////

   initial begin : hostModel
      int cycle;
      int pick;
      int nReady;
      int k;
      bit c0AlmPrev;   // Level the DUT saw at the last edge.
      bit c1AlmPrev;
      cycle       = 0;
      c0AlmPrev   = 1'b0;
      c1AlmPrev   = 1'b0;
      c0TxAlmFull = 1'b0;
      c1TxAlmFull = 1'b0;
      c0RxRdValid = 1'b0;
      c0RxMdata   = '0;
      c0RxData    = '0;
      c1RxWrValid = 1'b0;
      c1RxMdata   = '0;
      void'($urandom(32'h1810_2537));   // All random draws come from this process.
      forever begin
         @(posedge pClk);
         cycle++;
         if (!rst) begin
            if (c0TxValid) begin
               // Lines are requested in order from index zero.
               expectTrue(!c0AlmPrev, "read request after a cycle with c0TxAlmFull high");
               expectTrue(expRdIdx < curNum, "read request beyond the programmed line count");
               compareValue("c0TxMdata", c0TxMdata, mdata_t'(expRdIdx));
               compareValue("c0TxAddr", c0TxAddr, curSrc + clAddr_t'(expRdIdx));
               expRdIdx++;
               rdAddrQ.push_back(c0TxAddr);
               rdTagQ.push_back(c0TxMdata);
               rdDueQ.push_back(randomRsp ? cycle + 2 + $urandom_range(0, 24) : cycle + 3);
               issued++;
            end
            if (c1TxValid) begin
               expectTrue(!c1AlmPrev, "write request after a cycle with c1TxAlmFull high");
               compareValue("c1TxMdata", c1TxMdata, mdata_t'(c1TxAddr - curDst));
               hostMem[c1TxAddr] = c1TxData;
               cplTagQ.push_back(c1TxMdata);
               written++;
            end
            // Issued minus written equals the DUT's credit count one edge earlier.
            expectTrue(issued - written <= `AFU_BUF_DEPTH, "more reads outstanding than credits");
         end
         c0AlmPrev = c0TxAlmFull;
         c1AlmPrev = c1TxAlmFull;
         #1;
         c0RxRdValid = 1'b0;
         c1RxWrValid = 1'b0;
         pick        = -1;
         nReady      = 0;
         foreach (rdDueQ[i]) begin
            if (rdDueQ[i] <= cycle) nReady++;
         end
         if (nReady > 0) begin
            k = randomRsp ? $urandom_range(0, nReady - 1) : 0;
            foreach (rdDueQ[i]) begin
               if (rdDueQ[i] <= cycle) begin
                  if (k == 0 && pick < 0) pick = i;
                  k--;
               end
            end
         end
         if (pick >= 0) begin   // One read response per cycle.
            c0RxRdValid = 1'b1;
            c0RxMdata   = rdTagQ[pick];
            c0RxData    = hostMem.exists(rdAddrQ[pick]) ? hostMem[rdAddrQ[pick]] : '0;
            rdAddrQ.delete(pick);
            rdTagQ.delete(pick);
            rdDueQ.delete(pick);
         end
         if (cplTagQ.size() > 0) begin
            c1RxWrValid = 1'b1;
            c1RxMdata   = cplTagQ.pop_front();
         end
         if (almMode) begin   // Stretches of a few cycles on each channel.
            if ($urandom_range(0, 3) == 0) c0TxAlmFull = !c0TxAlmFull;
            if ($urandom_range(0, 3) == 0) c1TxAlmFull = !c1TxAlmFull;
         end else begin
            c0TxAlmFull = 1'b0;
            c1TxAlmFull = 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Directed tests.
   //////////////////////////////////////////////////////////////////////

   task automatic resetAndIdCheck();
      mmioData_t rd;
      int        waited;
      waited = 0;
      while (rst !== 1'b0 && waited < 20) begin
         @(posedge pClk);
         waited++;
      end
      expectTrue(rst === 1'b0, "reset was never released");
      @(posedge pClk);
      compareValue("c0TxValid", c0TxValid, 1'b0);
      compareValue("c1TxValid", c1TxValid, 1'b0);
      compareValue("c2TxMmioRdValid", c2TxMmioRdValid, 1'b0);
      mmioRead(AFU_ID, rd);
      compareValue("AFU_ID", rd, `AFU_ID);
   endtask

   task automatic csrReadBack();
      mmioData_t rd;
      mmioWrite(SRC, 64'h0000_0123_4567_89A0);
      mmioWrite(DST, 64'h0000_02AB_CDEF_0120);
      mmioWrite(NUM, 64'h0000_0000_0000_1234);
      mmioRead(SRC, rd);
      compareValue("SRC", rd, 64'h0000_0123_4567_89A0);
      mmioRead(DST, rd);
      compareValue("DST", rd, 64'h0000_02AB_CDEF_0120);
      mmioRead(NUM, rd);
      compareValue("NUM", rd, 64'h0000_0000_0000_1234);
      mmioRead(16'h0030, rd);   // Nothing lives here.
      compareValue("unmapped CSR 0x0030", rd, 64'd0);
   endtask

   task automatic inOrderCopy();
      randomRsp = 1'b0;
      almMode   = 1'b0;
      runCopy(42'h100, 42'h8000, 8, 1'b0);
   endtask

   task automatic randomOrderCopy();
      randomRsp = 1'b1;
      almMode   = 1'b0;
      runCopy(42'h2_0000, 42'h3_0000, 40, 1'b0);
   endtask

   task automatic backPressureCopy();
      randomRsp = 1'b1;
      almMode   = 1'b1;
      runCopy(42'h4_0000, 42'h5_0000, 24, 1'b1);
      runCopy(42'h2FF_FFFF_FF00, 42'h1FF_0000_0000, 30, 1'b0);   // High address bits.
      almMode = 1'b0;
   endtask

   initial begin : testSequence
      c0RxMmioWrValid = 1'b0;
      c0RxMmioRdValid = 1'b0;
      c0RxMmioAddr    = '0;
      c0RxMmioTid     = '0;
      c0RxMmioData    = '0;
      nextTid         = 9'h0A5;
      issued          = 0;
      written         = 0;
      expRdIdx        = 0;
      curSrc          = '0;
      curDst          = '0;
      curNum          = '0;
      randomRsp       = 1'b0;
      almMode         = 1'b0;
      checkCount      = 0;
      mismatchCount   = 0;
      failCount       = 0;
      resetAndIdCheck();
      csrReadBack();
      inOrderCopy();
      randomOrderCopy();
      backPressureCopy();
      repeat (5) @(posedge pClk);
      $display("Checks: %0d, mismatches: %0d, other failures: %0d",
               checkCount, mismatchCount, failCount);
      if (mismatchCount == 0 && failCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
src/ccipPkg.sv
src/afuPkg.sv
src/afuCtrl.sv
src/rdReqGen.sv
src/rspBuf.sv
src/wrReqGen.sv
src/ccipStdAfu.sv
verif/tbClkGen.sv
verif/tbTop.sv

// ==== Bender.yml ====
package:
  name: ccip_copy_afu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/ccipPkg.sv
      - src/afuPkg.sv
      - src/afuCtrl.sv
      - src/rdReqGen.sv
      - src/rspBuf.sv
      - src/wrReqGen.sv
      - src/ccipStdAfu.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tbClkGen.sv
      - verif/tbTop.sv
